//--- Makefile
SHELL := /bin/bash

VERILATOR ?= verilator
TOP       ?= tb_rv_core
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f sim.f

run: compile
	set -o pipefail; ./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim.f
+incdir+source
source/rv_pkg.sv
source/rv_decoder.sv
source/rv_regfile.sv
source/rv_datapath.sv
source/rv_data_bus.sv
source/rv_core.sv
test/rv_core_assertions.sv
test/tb_rv_core.sv

//--- source/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module rv_core import rv_pkg::*; (
  input  wire logic                  i_clk,
  input  wire logic                  i_reset,
  input  wire logic [`RV_XLEN-1:0]   i_inst,
  output logic      [`RV_XLEN-1:0]   o_pc,
  output logic                       o_wb_cyc,
  output logic                       o_wb_stb,
  output logic                       o_wb_we,
  output logic      [`RV_XLEN-1:0]   o_wb_adr,
  output logic      [`RV_XLEN-1:0]   o_wb_dat,
  output logic      [`RV_XLEN/8-1:0] o_wb_sel,
  input  wire logic [`RV_XLEN-1:0]   i_wb_dat,
  input  wire logic                  i_wb_ack
);

  pc_sel_e             pc_sel;
  logic                alu_src;
  imm_fmt_e            imm_fmt;
  alu_op_e             alu_op;
  logic                imm_plus_sel;
  result_sel_e         result_sel;
  logic                reg_write;
  mem_op_e             mem_op;
  logic                zero;
  logic                neg;
  logic                neg_u;
  logic                stall;
  logic [`RV_XLEN-1:0] alu_out;
  logic [`RV_XLEN-1:0] store_data;
  logic [`RV_XLEN-1:0] load_data;

  rv_decoder decoder0 (
    .i_inst         (i_inst),
    .i_zero         (zero),
    .i_neg          (neg),
    .i_neg_u        (neg_u),
    .o_pc_sel       (pc_sel),
    .o_alu_src      (alu_src),
    .o_imm_fmt      (imm_fmt),
    .o_alu_op       (alu_op),
    .o_imm_plus_sel (imm_plus_sel),
    .o_result_sel   (result_sel),
    .o_reg_write    (reg_write),
    .o_mem_op       (mem_op)
  );

  rv_datapath datapath0 (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_inst         (i_inst),
    .i_pc_sel       (pc_sel),
    .i_alu_src      (alu_src),
    .i_imm_fmt      (imm_fmt),
    .i_alu_op       (alu_op),
    .i_imm_plus_sel (imm_plus_sel),
    .i_result_sel   (result_sel),
    .i_reg_write    (reg_write),
    .i_stall        (stall),
    .i_load_data    (load_data),
    .o_pc           (o_pc),
    .o_alu_out      (alu_out),
    .o_store_data   (store_data),
    .o_zero         (zero),
    .o_neg          (neg),
    .o_neg_u        (neg_u)
  );

  // address comes from the ALU, store data from rs2
  rv_data_bus data_bus0 (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_mem_op     (mem_op),
    .i_addr       (alu_out),
    .i_store_data (store_data),
    .o_load_data  (load_data),
    .o_stall      (stall),
    .o_wb_cyc     (o_wb_cyc),
    .o_wb_stb     (o_wb_stb),
    .o_wb_we      (o_wb_we),
    .o_wb_adr     (o_wb_adr),
    .o_wb_dat     (o_wb_dat),
    .o_wb_sel     (o_wb_sel),
    .i_wb_dat     (i_wb_dat),
    .i_wb_ack     (i_wb_ack)
  );

endmodule

`default_nettype wire

//--- source/rv_data_bus.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module rv_data_bus import rv_pkg::*; (
  input  wire logic                  i_clk,
  input  wire logic                  i_reset,
  input  mem_op_e                    i_mem_op,
  input  wire logic [`RV_XLEN-1:0]   i_addr,
  input  wire logic [`RV_XLEN-1:0]   i_store_data,
  output logic      [`RV_XLEN-1:0]   o_load_data,
  output logic                       o_stall,
  output logic                       o_wb_cyc,
  output logic                       o_wb_stb,
  output logic                       o_wb_we,
  output logic      [`RV_XLEN-1:0]   o_wb_adr,
  output logic      [`RV_XLEN-1:0]   o_wb_dat,
  output logic      [`RV_XLEN/8-1:0] o_wb_sel,
  input  wire logic [`RV_XLEN-1:0]   i_wb_dat,
  input  wire logic                  i_wb_ack
);

  bus_state_e          state;
  logic                ack_q;
  logic                is_store;
  logic                aligned;
  logic                req;
  logic                start;
  logic [`RV_XLEN-1:0] shifted;

  assign is_store = (i_mem_op inside {MEM_SB, MEM_SH, MEM_SW});

  always_comb begin
    case (i_mem_op)
      MEM_LH, MEM_LHU, MEM_SH: aligned = ~i_addr[0];
      MEM_LW, MEM_SW:          aligned = (i_addr[1:0] == 2'b00);
      default:                 aligned = 1'b1;
    endcase
  end

  // misaligned ops never reach the bus
  assign req   = (i_mem_op != MEM_NONE) && aligned;
  // no transfer opens while reset is held
  assign start = (state == BUS_IDLE) && req && !ack_q && !i_reset;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state <= BUS_IDLE;
      ack_q <= 1'b0;
    end else begin
      // one idle cycle after every ack
      ack_q <= o_wb_cyc && i_wb_ack;
      case (state)
        BUS_IDLE:     if (start && !i_wb_ack) state <= BUS_WAIT_ACK;
        BUS_WAIT_ACK: if (i_wb_ack) state <= BUS_IDLE;
        default:      state <= BUS_IDLE;
      endcase
    end
  end

  assign o_wb_cyc = start || (state == BUS_WAIT_ACK);
  assign o_wb_stb = o_wb_cyc;
  assign o_wb_we  = o_wb_cyc && is_store;
  assign o_wb_adr = {i_addr[`RV_XLEN-1:2], 2'b00};

  // hold the PC until the closing ack
  assign o_stall = req && !(o_wb_cyc && i_wb_ack);

  // byte lanes and replicated store data
  always_comb begin
    case (i_mem_op)
      MEM_LB, MEM_LBU, MEM_SB: begin
        o_wb_sel = 4'b0001 << i_addr[1:0];
        o_wb_dat = {4{i_store_data[7:0]}};
      end
      MEM_LH, MEM_LHU, MEM_SH: begin
        o_wb_sel = i_addr[1] ? 4'b1100 : 4'b0011;
        o_wb_dat = {2{i_store_data[15:0]}};
      end
      default: begin
        o_wb_sel = 4'b1111;
        o_wb_dat = i_store_data;
      end
    endcase
  end

  // load alignment and extension
  assign shifted = i_wb_dat >> {i_addr[1:0], 3'b000};

  always_comb begin
    case (i_mem_op)
      MEM_LB:  o_load_data = {{(`RV_XLEN-8){shifted[7]}}, shifted[7:0]};
      MEM_LBU: o_load_data = {{(`RV_XLEN-8){1'b0}}, shifted[7:0]};
      MEM_LH:  o_load_data = {{(`RV_XLEN-16){shifted[15]}}, shifted[15:0]};
      MEM_LHU: o_load_data = {{(`RV_XLEN-16){1'b0}}, shifted[15:0]};
      MEM_LW:  o_load_data = shifted;
      default: o_load_data = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- source/rv_datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module rv_datapath import rv_pkg::*; (
  input  wire logic                i_clk,
  input  wire logic                i_reset,
  input  wire logic [`RV_XLEN-1:0] i_inst,
  input  pc_sel_e                  i_pc_sel,
  input  wire logic                i_alu_src,
  input  imm_fmt_e                 i_imm_fmt,
  input  alu_op_e                  i_alu_op,
  input  wire logic                i_imm_plus_sel,
  input  result_sel_e              i_result_sel,
  input  wire logic                i_reg_write,
  input  wire logic                i_stall,
  input  wire logic [`RV_XLEN-1:0] i_load_data,
  output logic      [`RV_XLEN-1:0] o_pc,
  output logic      [`RV_XLEN-1:0] o_alu_out,
  output logic      [`RV_XLEN-1:0] o_store_data,
  output logic                     o_zero,
  output logic                     o_neg,
  output logic                     o_neg_u
);

  localparam int SHW = $clog2(`RV_XLEN);

  logic [4:0]          rd;
  logic [4:0]          rs1;
  logic [4:0]          rs2;
  logic [`RV_XLEN-1:0] imm;
  logic [`RV_XLEN-1:0] pc_plus4;
  logic [`RV_XLEN-1:0] pc_plus_imm;
  logic [`RV_XLEN-1:0] jalr_target;
  logic [`RV_XLEN-1:0] pc_next;
  logic [`RV_XLEN-1:0] alu_a;
  logic [`RV_XLEN-1:0] alu_b;
  logic [`RV_XLEN-1:0] imm_plus;
  logic [`RV_XLEN-1:0] result;
  logic [SHW-1:0]      shamt;

  assign rd  = i_inst[11:7];
  assign rs1 = i_inst[19:15];
  assign rs2 = i_inst[24:20];

  // program counter, held while the bus unit stalls
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_pc <= `RV_RESET_PC;
    end else if (!i_stall) begin
      o_pc <= pc_next;
    end
  end

  assign pc_plus4    = o_pc + `RV_XLEN'd4;
  assign pc_plus_imm = o_pc + imm;
  assign jalr_target = {o_alu_out[`RV_XLEN-1:1], 1'b0};

  always_comb begin
    case (i_pc_sel)
      PC_PLUS_IMM: pc_next = pc_plus_imm;
      PC_JALR:     pc_next = jalr_target;
      default:     pc_next = pc_plus4;
    endcase
  end

  // immediate extender
  always_comb begin
    case (i_imm_fmt)
      IMM_S: imm = {{(`RV_XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
      IMM_B: imm = {{(`RV_XLEN-13){i_inst[31]}}, i_inst[31], i_inst[7],
                    i_inst[30:25], i_inst[11:8], 1'b0};
      IMM_U: imm = {i_inst[31:12], 12'b0};
      IMM_J: imm = {{(`RV_XLEN-21){i_inst[31]}}, i_inst[31], i_inst[19:12],
                    i_inst[20], i_inst[30:21], 1'b0};
      default: imm = {{(`RV_XLEN-12){i_inst[31]}}, i_inst[31:20]};
    endcase
  end

  rv_regfile regfile0 (
    .i_clk    (i_clk),
    .i_reset  (i_reset),
    .i_we     (i_reg_write && !i_stall),
    .i_rs1    (rs1),
    .i_rs2    (rs2),
    .i_rd     (rd),
    .i_wdata  (result),
    .o_rdata1 (alu_a),
    .o_rdata2 (o_store_data)
  );

  // ALU
  assign alu_b = i_alu_src ? imm : o_store_data;
  assign shamt = alu_b[SHW-1:0];

  always_comb begin
    case (i_alu_op)
      ALU_SUB:  o_alu_out = alu_a - alu_b;
      ALU_SLL:  o_alu_out = alu_a << shamt;
      ALU_SLT:  o_alu_out = {{(`RV_XLEN-1){1'b0}}, o_neg};
      ALU_SLTU: o_alu_out = {{(`RV_XLEN-1){1'b0}}, o_neg_u};
      ALU_XOR:  o_alu_out = alu_a ^ alu_b;
      ALU_SRL:  o_alu_out = alu_a >> shamt;
      ALU_SRA:  o_alu_out = $unsigned($signed(alu_a) >>> shamt);
      ALU_OR:   o_alu_out = alu_a | alu_b;
      ALU_AND:  o_alu_out = alu_a & alu_b;
      default:  o_alu_out = alu_a + alu_b;
    endcase
  end

  // compare flags for branches and set-less-than
  assign o_zero  = (o_alu_out == '0);
  assign o_neg   = ($signed(alu_a) < $signed(alu_b));
  assign o_neg_u = (alu_a < alu_b);

  // result selection
  assign imm_plus = i_imm_plus_sel ? pc_plus_imm : imm;

  always_comb begin
    case (i_result_sel)
      RES_LOAD:     result = i_load_data;
      RES_IMM_PLUS: result = imm_plus;
      RES_PC_PLUS4: result = pc_plus4;
      default:      result = o_alu_out;
    endcase
  end

endmodule

`default_nettype wire

//--- source/rv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module rv_decoder import rv_pkg::*; (
  input  wire logic [`RV_XLEN-1:0] i_inst,
  input  wire logic                i_zero,
  input  wire logic                i_neg,
  input  wire logic                i_neg_u,
  output pc_sel_e                  o_pc_sel,
  output logic                     o_alu_src,
  output imm_fmt_e                 o_imm_fmt,
  output alu_op_e                  o_alu_op,
  output logic                     o_imm_plus_sel,
  output result_sel_e              o_result_sel,
  output logic                     o_reg_write,
  output mem_op_e                  o_mem_op
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       alt;
  logic       taken;

  assign opcode = opcode_e'(i_inst[6:0]);
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];
  assign alt    = i_inst[30];

  // funct3 to ALU op; alt picks SUB / SRA where allowed
  function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic sub_ok,
                                          input logic alt_bit);
    case (f3)
      3'b000:  return (sub_ok && alt_bit) ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt_bit ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // branch outcome from the SUB compare flags
  always_comb begin
    case (funct3)
      3'b000:  taken = i_zero;
      3'b001:  taken = ~i_zero;
      3'b100:  taken = i_neg;
      3'b101:  taken = ~i_neg;
      3'b110:  taken = i_neg_u;
      3'b111:  taken = ~i_neg_u;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    // defaults describe a no-op
    o_pc_sel       = PC_PLUS4;
    o_alu_src      = 1'b0;
    o_imm_fmt      = IMM_I;
    o_alu_op       = ALU_ADD;
    o_imm_plus_sel = 1'b0;
    o_result_sel   = RES_ALU;
    o_reg_write    = 1'b0;
    o_mem_op       = MEM_NONE;

    case (opcode)
      OPC_LOAD: begin
        o_alu_src    = 1'b1;
        o_result_sel = RES_LOAD;
        case (funct3)
          3'b000:  o_mem_op = MEM_LB;
          3'b001:  o_mem_op = MEM_LH;
          3'b010:  o_mem_op = MEM_LW;
          3'b100:  o_mem_op = MEM_LBU;
          3'b101:  o_mem_op = MEM_LHU;
          default: o_mem_op = MEM_NONE;
        endcase
        o_reg_write = (o_mem_op != MEM_NONE);
      end
      OPC_STORE: begin
        o_alu_src = 1'b1;
        o_imm_fmt = IMM_S;
        case (funct3)
          3'b000:  o_mem_op = MEM_SB;
          3'b001:  o_mem_op = MEM_SH;
          3'b010:  o_mem_op = MEM_SW;
          default: o_mem_op = MEM_NONE;
        endcase
      end
      OPC_OP_IMM: begin
        o_alu_src   = 1'b1;
        o_alu_op    = alu_from_f3(funct3, 1'b0, alt);
        o_reg_write = 1'b1;
      end
      OPC_OP: begin
        o_alu_op    = alu_from_f3(funct3, 1'b1, alt);
        // only funct7 0000000 and 0100000 (with ADD/SRL slots) exist
        o_reg_write = (funct7 == 7'b0000000) ||
                      (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
      end
      OPC_LUI: begin
        o_imm_fmt    = IMM_U;
        o_result_sel = RES_IMM_PLUS;
        o_reg_write  = 1'b1;
      end
      OPC_AUIPC: begin
        o_imm_fmt      = IMM_U;
        o_imm_plus_sel = 1'b1;
        o_result_sel   = RES_IMM_PLUS;
        o_reg_write    = 1'b1;
      end
      OPC_BRANCH: begin
        o_imm_fmt = IMM_B;
        o_alu_op  = ALU_SUB;
        o_pc_sel  = taken ? PC_PLUS_IMM : PC_PLUS4;
      end
      OPC_JAL: begin
        o_imm_fmt    = IMM_J;
        o_pc_sel     = PC_PLUS_IMM;
        o_result_sel = RES_PC_PLUS4;
        o_reg_write  = 1'b1;
      end
      OPC_JALR: begin
        if (funct3 == 3'b000) begin
          o_alu_src    = 1'b1;
          o_pc_sel     = PC_JALR;
          o_result_sel = RES_PC_PLUS4;
          o_reg_write  = 1'b1;
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- source/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// machine word width
`define RV_XLEN 32

// architectural integer registers
`define RV_NREGS 32

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif

//--- source/rv_pkg.sv
`default_nettype none

package rv_pkg;

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_e;

  typedef enum logic [2:0] {
    IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
  } imm_fmt_e;

  // third input is imm (LUI) or pc + imm (AUIPC)
  typedef enum logic [1:0] {
    RES_ALU, RES_LOAD, RES_IMM_PLUS, RES_PC_PLUS4
  } result_sel_e;

  typedef enum logic [1:0] {
    PC_PLUS4, PC_PLUS_IMM, PC_JALR
  } pc_sel_e;

  typedef enum logic [3:0] {
    MEM_NONE, MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU,
    MEM_SB, MEM_SH, MEM_SW
  } mem_op_e;

  typedef enum logic {
    BUS_IDLE, BUS_WAIT_ACK
  } bus_state_e;

endpackage

`default_nettype wire

//--- source/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module rv_regfile (
  input  wire logic                i_clk,
  input  wire logic                i_reset,
  input  wire logic                i_we,
  input  wire logic [4:0]          i_rs1,
  input  wire logic [4:0]          i_rs2,
  input  wire logic [4:0]          i_rd,
  input  wire logic [`RV_XLEN-1:0] i_wdata,
  output logic      [`RV_XLEN-1:0] o_rdata1,
  output logic      [`RV_XLEN-1:0] o_rdata2
);

  logic [`RV_XLEN-1:0] regs [`RV_NREGS];

  // x0 is never written, so it reads zero after reset
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && i_rd != 5'd0) begin
      regs[i_rd] <= i_wdata;
    end
  end

  assign o_rdata1 = regs[i_rs1];
  assign o_rdata2 = regs[i_rs2];

endmodule

`default_nettype wire

//--- test/rv_core_assertions.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module rv_core_assertions (
  input wire logic                  i_clk,
  input wire logic                  i_reset,
  input wire logic [`RV_XLEN-1:0]   o_pc,
  input wire logic                  o_wb_cyc,
  input wire logic                  o_wb_stb,
  input wire logic                  o_wb_we,
  input wire logic [`RV_XLEN-1:0]   o_wb_adr,
  input wire logic [`RV_XLEN-1:0]   o_wb_dat,
  input wire logic [`RV_XLEN/8-1:0] o_wb_sel,
  input wire logic                  i_wb_ack,
  input wire logic                  i_stall
);

  // a memory op held in the idle gap opens its transfer one cycle later
  one_idle_cycle: assert property (@(posedge i_clk) disable iff (i_reset)
    (i_stall && !o_wb_cyc) |=> o_wb_cyc)
    else $error("transfer not opened after the idle cycle");

  // an open transfer keeps every master output until ack
  hold_until_ack: assert property (@(posedge i_clk) disable iff (i_reset)
    (o_wb_cyc && !i_wb_ack) |=> (o_wb_cyc && o_wb_stb && $stable(o_wb_we) &&
      $stable(o_wb_adr) && $stable(o_wb_dat) && $stable(o_wb_sel)))
    else $error("wishbone master outputs changed before ack");

  drop_after_ack: assert property (@(posedge i_clk) disable iff (i_reset)
    (o_wb_cyc && i_wb_ack) |=> (!o_wb_cyc && !o_wb_stb))
    else $error("wishbone strobes still high in the cycle after ack");

  pc_held_in_stall: assert property (@(posedge i_clk) disable iff (i_reset)
    i_stall |=> $stable(o_pc))
    else $error("pc moved while the core was stalled");

endmodule

bind rv_core rv_core_assertions asrt0 (
  .i_clk    (i_clk),
  .i_reset  (i_reset),
  .o_pc     (o_pc),
  .o_wb_cyc (o_wb_cyc),
  .o_wb_stb (o_wb_stb),
  .o_wb_we  (o_wb_we),
  .o_wb_adr (o_wb_adr),
  .o_wb_dat (o_wb_dat),
  .o_wb_sel (o_wb_sel),
  .i_wb_ack (i_wb_ack),
  .i_stall  (stall)
);

`default_nettype wire

//--- test/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module tb_rv_core;

  localparam int N_INST = 200;
  localparam int END_PC = (N_INST - 1) * 4;
  localparam int LIMIT  = N_INST * 6 + 20;

  // a store word fetched while reset is held
  localparam logic [31:0] RESET_INST = 32'h0000_2023;

  logic        i_clk;
  logic        i_reset;
  logic [31:0] i_inst;
  logic [31:0] o_pc;
  logic        o_wb_cyc;
  logic        o_wb_stb;
  logic        o_wb_we;
  logic [31:0] o_wb_adr;
  logic [31:0] o_wb_dat;
  logic [3:0]  o_wb_sel;
  logic [31:0] i_wb_dat;
  logic        i_wb_ack;

  logic [31:0] rom [256];
  logic [31:0] mem [64];
  logic [31:0] m_mem [64];
  logic [31:0] m_regs [`RV_NREGS];
  logic [31:0] m_pc;
  logic [31:0] rng;
  int          wait_cnt;
  int          cycles;
  int          n_mismatch;
  int          n_other;
  bit          done;

  rv_core dut0 (.*);

  assign i_inst = i_reset ? RESET_INST : rom[o_pc[9:2]];

  initial begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
  end

  function automatic logic [31:0] rnd();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic logic [31:0] itype_inst(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] rtype_inst(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] stype_inst(input logic [11:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] btype_inst(input logic [12:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] jtype_inst(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  // fill word depends on every address bit
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9e37_79b1) ^ {addr[15:0], ~addr[15:0]};
  endfunction

  // x20 holds the data base 0x1000 and x21 the jalr base
  task automatic gen_program();
    int          i;
    int          kind;
    int          off;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [6:0]  f7;
    logic [2:0]  br_f3 [6];
    logic [2:0]  ld_f3 [5];
    // landing slots of branches and jal
    bit          target [N_INST];
    br_f3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    ld_f3 = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
    for (i = 0; i < 256; i++) begin
      rom[i] = 32'h0;
    end
    for (i = 0; i < N_INST; i++) begin
      target[i] = 1'b0;
    end
    rom[0] = {20'h00001, 5'd20, 7'h37};
    i = 1;
    while (i < N_INST - 1) begin
      kind = rnd() % 10;
      f3 = 3'(rnd() % 8);
      if (kind <= 2) begin
        imm = 12'(rnd() % 4096);
        if (f3 == 3'd1) imm = 12'(rnd() % 32);
        if (f3 == 3'd5) imm = 12'(rnd() % 32) | ((rnd() % 2) ? 12'h400 : 12'h000);
        rom[i] = itype_inst(imm, 5'(rnd() % 16), f3, 5'(rnd() % 16), 7'h13);
      end else if (kind == 3) begin
        rom[i] = {20'(rnd() % 32'h100000), 5'(rnd() % 16), 7'h37};
      end else if (kind <= 5) begin
        f7 = ((f3 == 3'd0 || f3 == 3'd5) && (rnd() % 2)) ? 7'h20 : 7'h00;
        rom[i] = rtype_inst(f7, 5'(rnd() % 16), 5'(rnd() % 16), f3, 5'(rnd() % 16));
      end else if (kind == 6) begin
        f3 = 3'(rnd() % 3);
        imm = 12'(rnd() % 256) & ~((12'd1 << f3) - 12'd1);
        rom[i] = stype_inst(imm, 5'(rnd() % 16), 5'd20, f3);
      end else if (kind == 7) begin
        f3 = ld_f3[rnd() % 5];
        imm = 12'(rnd() % 256) & ~((12'd1 << f3[1:0]) - 12'd1);
        rom[i] = itype_inst(imm, 5'd20, f3, 5'(rnd() % 16), 7'h03);
      end else if (kind == 8) begin
        off = (2 + rnd() % 3) * 4;
        if (i + off / 4 > N_INST - 1) off = (N_INST - 1 - i) * 4;
        target[i + off / 4] = 1'b1;
        if (rnd() % 2)
          rom[i] = btype_inst(13'(off), 5'(rnd() % 16), 5'(rnd() % 16), br_f3[rnd() % 6]);
        else
          rom[i] = jtype_inst(21'(off), 5'(rnd() % 16));
      end else if (i + 3 <= N_INST - 1 && !target[i + 1]) begin
        // odd offset 13 lands on pc + 12 once bit zero is cleared
        rom[i] = {20'h0, 5'd21, 7'h17};
        rom[i + 1] = itype_inst(12'd13, 5'd21, 3'd0, 5'(rnd() % 16), 7'h67);
        rom[i + 2] = itype_inst(12'd1, 5'd1, 3'd0, 5'd1, 7'h13);
        i = i + 2;
      end else begin
        rom[i] = itype_inst(12'd5, 5'd2, 3'd0, 5'd2, 7'h13);
      end
      i++;
    end
    // final jump to itself
    rom[N_INST - 1] = jtype_inst(21'd0, 5'd0);
  endtask

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic sub,
                                          input logic alt, input logic [31:0] a,
                                          input logic [31:0] b);
    case (f3)
      3'd0:    return sub ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'd0, $signed(a) < $signed(b)};
      3'd3:    return {31'd0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL %0t %s: got %h expected %h", $time, name, got, exp);
      n_mismatch++;
    end
  endtask

  // one instruction of the ISA model plus bus checks for loads and stores
  task automatic model_step(input logic [31:0] inst);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] iimm;
    logic [31:0] nxt;
    logic [31:0] addr;
    logic [31:0] val;
    logic [3:0]  sel;
    logic [2:0]  f3;
    logic [4:0]  rd;
    bit          wr;
    bit          tk;
    a = m_regs[inst[19:15]];
    b = m_regs[inst[24:20]];
    f3 = inst[14:12];
    rd = inst[11:7];
    iimm = {{20{inst[31]}}, inst[31:20]};
    nxt = m_pc + 4;
    wr = 1'b1;
    val = 32'h0;
    case (inst[6:0])
      7'h37: val = {inst[31:12], 12'h0};
      7'h17: val = m_pc + {inst[31:12], 12'h0};
      7'h6f: begin
        val = m_pc + 4;
        nxt = m_pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      7'h67: begin
        val = m_pc + 4;
        nxt = (a + iimm) & ~32'd1;
      end
      7'h63: begin
        wr = 1'b0;
        case (f3)
          3'd0:    tk = (a == b);
          3'd1:    tk = (a != b);
          3'd4:    tk = ($signed(a) < $signed(b));
          3'd5:    tk = ($signed(a) >= $signed(b));
          3'd6:    tk = (a < b);
          default: tk = (a >= b);
        endcase
        if (tk) nxt = m_pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      end
      7'h03, 7'h23: begin
        if (inst[6:0] == 7'h23) iimm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        addr = a + iimm;
        sel = (f3[1:0] == 2'd0) ? 4'b0001 : (f3[1:0] == 2'd1) ? 4'b0011 : 4'b1111;
        sel = sel << addr[1:0];
        check_val("o_wb_adr", o_wb_adr, {addr[31:2], 2'b00});
        check_val("o_wb_sel", {28'd0, o_wb_sel}, {28'd0, sel});
        check_val("o_wb_we", {31'd0, o_wb_we}, {31'd0, inst[5]});
        if (inst[5]) begin
          wr = 1'b0;
          b = b << (8 * addr[1:0]);
          for (int k = 0; k < 4; k++) begin
            if (sel[k]) begin
              check_val("o_wb_dat lane", {24'd0, o_wb_dat[8*k +: 8]}, {24'd0, b[8*k +: 8]});
              m_mem[addr[7:2]][8*k +: 8] = b[8*k +: 8];
            end
          end
        end else begin
          val = m_mem[addr[7:2]] >> (8 * addr[1:0]);
          case (f3)
            3'd0:    val = {{24{val[7]}}, val[7:0]};
            3'd1:    val = {{16{val[15]}}, val[15:0]};
            3'd4:    val = {24'd0, val[7:0]};
            3'd5:    val = {16'd0, val[15:0]};
            default: ;
          endcase
        end
      end
      7'h13: val = alu_ref(f3, 1'b0, inst[30], a, iimm);
      7'h33: val = alu_ref(f3, inst[30], inst[30], a, b);
      default: wr = 1'b0;
    endcase
    if (wr && rd != 5'd0) m_regs[rd] = val;
    m_pc = nxt;
  endtask

  // model runs mid-cycle where the DUT outputs are settled
  always @(negedge i_clk) begin
    logic [31:0] inst;
    if (i_reset) begin
      check_val("o_wb_cyc", {31'd0, o_wb_cyc}, 32'd0);
      check_val("o_wb_stb", {31'd0, o_wb_stb}, 32'd0);
      check_val("o_wb_we", {31'd0, o_wb_we}, 32'd0);
    end else if (!done) begin
      check_val("o_pc", o_pc, m_pc);
      inst = rom[m_pc[9:2]];
      if (m_pc == END_PC) begin
        done = 1'b1;
      end else if (inst[6:0] == 7'h03 || inst[6:0] == 7'h23) begin
        if (o_wb_cyc && i_wb_ack) model_step(inst);
      end else begin
        model_step(inst);
      end
    end
  end

  // wishbone slave with 0 to 3 wait states
  always @(posedge i_clk) begin
    logic rst_at_edge;
    // reset as seen at the clock edge
    rst_at_edge = i_reset;
    #2;
    if (rst_at_edge || i_wb_ack) begin
      i_wb_ack = 1'b0;
    end else if (o_wb_cyc) begin
      if (wait_cnt == 0) begin
        i_wb_ack = 1'b1;
        i_wb_dat = mem[o_wb_adr[7:2]];
        wait_cnt = rnd() % 4;
      end else begin
        wait_cnt--;
      end
    end
  end

  always @(negedge i_clk) begin
    if (o_wb_cyc && i_wb_ack) begin
      if (o_wb_adr[31:8] != 24'h10) begin
        $display("bus access outside the data region at %0t", $time);
        n_other++;
      end
      if (o_wb_we) begin
        for (int k = 0; k < 4; k++) begin
          if (o_wb_sel[k]) mem[o_wb_adr[7:2]][8*k +: 8] = o_wb_dat[8*k +: 8];
        end
      end
    end
  end

  initial begin
    i_reset = 1'b1;
    i_wb_ack = 1'b0;
    i_wb_dat = 32'h0;
    rng = 32'd21521;
    wait_cnt = 0;
    cycles = 0;
    n_mismatch = 0;
    n_other = 0;
    done = 1'b0;
    m_pc = `RV_RESET_PC;
    for (int r = 0; r < `RV_NREGS; r++) begin
      m_regs[r] = 32'h0;
    end
    for (int w = 0; w < 64; w++) begin
      mem[w] = fill_word(32'h1000 + 4 * w);
      m_mem[w] = mem[w];
    end
    gen_program();
    repeat (5) @(posedge i_clk);
    #2 i_reset = 1'b0;
    while (!done && cycles < LIMIT) begin
      @(posedge i_clk);
      cycles++;
    end
    if (!done) begin
      $display("timeout: program end not reached after %0d cycles", cycles);
      n_other++;
    end
    $display("errors: %0d mismatches, %0d other failures", n_mismatch, n_other);
    if (n_mismatch == 0 && n_other == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
